// File: duc.f
duc_pkg.sv
duc_settings.sv
cic_interp.sv
phase_rotator.sv
iq_scaler.sv
duc_top.sv
duc_checker.sv
duc_tb_clock.sv
duc_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the DUC testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module duc_tb -f duc.f -o duc_sim \
  && ./obj_dir/duc_sim | tee /dev/stderr | grep -qF "TEST RESULT: PASS" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: duc_tb.sv
`timescale 1ns/100ps

module duc_tb import duc_pkg::*; ();

  logic                 clk;
  logic                 reset;
  logic                 i_clear;
  logic                 i_set_stb;
  logic [SR_ADDR_W-1:0] i_set_addr;
  set_word_u            i_set_data;
  iq_sample_t           i_data;
  logic                 i_valid;
  logic                 o_ready;
  iq_sample_t           o_data;
  logic                 o_valid;
  logic                 i_ready;

  integer     seed = 71200;
  int         errors = 0;
  int         checks = 0;
  int         out_count = 0;
  int         sat_count = 0;
  int         cycles = 0;
  bit         stall_on = 1'b0;
  iq_sample_t last_out;
  iq_sample_t exp_q[$];  // Expected output words in order
  iq_sample_t stim[$];

  // Model state: comb delays x and c1, then integrators 1 and 2, per rail
  logic signed [CIC_W-1:0] cic_st [4][2];
  logic [PHASE_W-1:0]      m_phase;
  logic [PHASE_W-1:0]      m_inc;
  logic [SCALE_W-1:0]      m_scale;
  int                      m_rate_log;
  int                      m_pend_log;  // Rate held while busy
  bit                      m_pend;
  bit                      m_active;

  duc_tb_clock u_clock (.o_clk(clk));

  duc_top i_dut (
    .clk(clk), .reset(reset), .i_clear(i_clear),
    .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .i_data(i_data), .i_valid(i_valid), .o_ready(o_ready),
    .o_data(o_data), .o_valid(o_valid), .i_ready(i_ready)
  );

  function automatic logic signed [SAMPLE_W-1:0] clip16(input longint v);
    if (v > 32767) return 16'sd32767;
    if (v < -32767) return -16'sd32767;  // Symmetric range
    return v[15:0];
  endfunction

  // Rotate one CIC output by ph, then scale, round half up and clip
  function automatic iq_sample_t ref_duc(input iq_sample_t s, input logic [PHASE_W-1:0] ph,
                                         input logic [SCALE_W-1:0] scl);
    logic signed [CORDIC_W-1:0] x;
    logic signed [CORDIC_W-1:0] y;
    logic signed [CORDIC_W-1:0] t;
    logic [PHASE_W-1:0]         z;
    iq_sample_t                 r;
    x = {{4{s.i[15]}}, s.i, 2'b00};  // Two fraction bits
    y = {{4{s.q[15]}}, s.q, 2'b00};
    if (ph[14]) begin  // Odd quarter turn
      t = x;
      x = -y;
      y = t;
    end
    if (ph[15]) begin  // Half turn
      x = -x;
      y = -y;
    end
    z = {2'b00, ph[13:0]};
    for (int k = 0; k < CORDIC_ITER; k++) begin
      t = x;
      if (z[15]) begin  // Overshot, turn back
        x = x + (y >>> k);
        y = y - (t >>> k);
        z = z + CORDIC_ATAN[k];
      end else begin
        x = x - (y >>> k);
        y = y + (t >>> k);
        z = z - CORDIC_ATAN[k];
      end
    end
    r.i = clip16((clip16(x >>> 2) * longint'(scl) + 8192) >>> 14);
    r.q = clip16((clip16(y >>> 2) * longint'(scl) + 8192) >>> 14);
    return r;
  endfunction

  function automatic bit near(input logic signed [SAMPLE_W-1:0] v, input int want);
    return (int'(v) - want <= 8) && (want - int'(v) <= 8);  // CORDIC residual slack
  endfunction

  task automatic clear_model(input bit phase_too);
    for (int a = 0; a < 4; a++) begin
      cic_st[a][0] = '0;
      cic_st[a][1] = '0;
    end
    if (phase_too) m_phase = '0;
  endtask

  // One accepted input gives 2^rate_log expected words
  task automatic predict_input(input iq_sample_t s);
    logic signed [CIC_W-1:0] x;
    logic signed [CIC_W-1:0] c1;
    logic signed [CIC_W-1:0] y;
    iq_sample_t              c;
    for (int n = 0; n < (1 << m_rate_log); n++) begin
      for (int r = 0; r < 2; r++) begin
        if (n == 0) begin  // Comb output only on the first, zeros after
          x = r ? {{CIC_EXTRA_W{s.q[15]}}, s.q} : {{CIC_EXTRA_W{s.i[15]}}, s.i};
          c1 = x - cic_st[0][r];
          cic_st[2][r] += c1 - cic_st[1][r];
          cic_st[0][r] = x;
          cic_st[1][r] = c1;
        end
        cic_st[3][r] += cic_st[2][r];
        y = cic_st[3][r] >>> m_rate_log;  // Gain R out
        if (r == 0) c.i = y[15:0];
        else c.q = y[15:0];
      end
      exp_q.push_back(ref_duc(c, m_phase, m_scale));
      m_phase += m_inc;  // Old phase used, then advance
    end
    m_active = 1'b1;
  endtask

  task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, want);
    end
  endtask

  task automatic write_setting(input logic [SR_ADDR_W-1:0] addr, input logic [SET_W-1:0] data);
    i_set_stb  = 1'b1;
    i_set_addr = addr;
    i_set_data = data;
    @(posedge clk);
    #0.5 i_set_stb = 1'b0;
    if (addr == SR_PHASE_INC) m_inc = data[15:0];
    if (addr == SR_SCALE) m_scale = data[17:0];
    if (addr == SR_INTERP && m_active) begin  // Busy, wait for idle
      m_pend     = 1'b1;
      m_pend_log = data[2:0];
    end else if (addr == SR_INTERP) begin
      m_rate_log = data[2:0];
      clear_model(1'b0);  // CIC reload
    end
    repeat (3) @(posedge clk);
    #0.5;
  endtask

  task automatic clear_chain();
    i_clear = 1'b1;
    @(posedge clk);
    #0.5 i_clear = 1'b0;
    clear_model(1'b1);
    m_active = 1'b0;
    if (m_pend) begin
      m_rate_log = m_pend_log;
      m_pend     = 1'b0;
    end
    repeat (4) @(posedge clk);  // Held rate lands in here
    #0.5;
  endtask

  task automatic send_sample(input iq_sample_t s);
    bit took;
    i_data  = s;
    i_valid = 1'b1;
    do begin
      @(negedge clk);
      took = o_ready;  // Transfer at the coming edge
      if (took) predict_input(s);
      @(posedge clk);
      #0.5;
    end while (!took);
    i_valid = 1'b0;
  endtask

  task automatic send_random(input int n);
    iq_sample_t s;
    for (int k = 0; k < n; k++) begin
      s = $random(seed);
      send_sample(s);
    end
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) @(posedge clk);
    repeat (20) @(posedge clk);  // Room for a stray extra word
    #0.5;
  endtask

  task automatic end_test(input string name, input int err0);
    $display("%s: %0d outputs, %0d errors", name, out_count, errors - err0);
  endtask

  always @(posedge clk) begin
    #0.5;
    if (stall_on) i_ready = ($unsigned($random(seed)) % 100) >= 40;  // Low 40% of cycles
    else i_ready = 1'b1;
  end

  always @(negedge clk) begin
    if (!reset && o_valid === 1'b1 && i_ready) begin
      out_count++;
      last_out = o_data;
      if (o_data.i == 16'sh7fff || o_data.i == -16'sh7fff) sat_count++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("Error at %0t ns: output word with nothing expected", $time);
      end else begin
        check_val("o_data", o_data, exp_q.pop_front());
      end
    end
  end

  // About 150 inputs and 700 outputs here, so 40000 cycles leaves wide margin
  always @(posedge clk) begin
    cycles++;
    if (cycles >= 40000) begin
      $display("Run stopped at cycle %0d: outputs stopped arriving", cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    int         err0;
    int         rl;
    iq_sample_t s;
    reset      = 1'b1;
    i_clear    = 1'b0;
    i_set_stb  = 1'b0;
    i_set_addr = '0;
    i_set_data = '0;
    i_data     = '0;
    i_valid    = 1'b0;
    i_ready    = 1'b1;
    m_inc      = '0;
    m_scale    = 18'd16384;  // 1.0
    m_rate_log = 0;
    m_pend     = 1'b0;
    m_active   = 1'b0;
    clear_model(1'b1);
    repeat (4) @(posedge clk);
    #0.5 reset = 1'b0;

    err0 = errors;
    repeat (3) @(posedge clk);
    #0.5;
    check_val("o_valid after reset", o_valid, 0);
    check_val("o_ready after reset", o_ready, 1);
    send_random(20);
    wait_drain();
    check_val("outputs at rate 1", out_count, 20);
    end_test("Test 1 reset and rate 1", err0);

    err0 = errors;
    out_count = 0;
    for (int j = 0; j < 3; j++) begin
      rl = (j == 2) ? 4 : j + 1;  // R = 2, 4, 16
      clear_chain();
      write_setting(SR_INTERP, rl);
      out_count = 0;
      send_random(6);
      s.i = 16'sd8000;
      s.q = -16'sd4000;
      repeat (3) send_sample(s);
      wait_drain();
      check_val("outputs for rate", out_count, 9 << rl);
      check_val("DC level I", near(last_out.i, 13174), 1);  // 8000 x 1.64676
      check_val("DC level Q", near(last_out.q, -6587), 1);
    end
    end_test("Test 2 interpolation", err0);

    err0 = errors;
    clear_chain();
    write_setting(SR_INTERP, 1);
    write_setting(SR_PHASE_INC, 32'h1357);
    out_count = 0;
    send_random(30);
    wait_drain();
    check_val("outputs with shift", out_count, 60);
    end_test("Test 3 frequency shift", err0);

    err0 = errors;
    clear_chain();
    write_setting(SR_INTERP, 3);
    for (int k = 0; k < 40; k++) stim.push_back($random(seed));
    stall_on = 1'b1;
    out_count = 0;
    while (stim.size() != 0) send_sample(stim.pop_front());
    wait_drain();
    stall_on = 1'b0;
    check_val("outputs under stalls", out_count, 320);
    end_test("Test 4 back-pressure", err0);

    err0 = errors;
    clear_chain();
    write_setting(SR_INTERP, 0);
    out_count = 0;
    send_random(4);
    write_setting(SR_INTERP, 1);  // Chain busy, rate held
    send_random(4);
    wait_drain();
    check_val("outputs before clear", out_count, 8);
    clear_chain();
    write_setting(SR_SCALE, 32'h3ffff);  // Close to 16x
    out_count = 0;
    sat_count = 0;
    send_random(4);
    wait_drain();
    check_val("outputs after clear", out_count, 8);
    check_val("saturated outputs seen", sat_count > 0, 1);
    end_test("Test 5 deferred rate and clip", err0);

    errors += i_dut.u_checker.fail_cnt;
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) $display("TEST RESULT: PASS");
    else $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: duc_tb_clock.sv
`timescale 1ns/100ps

module duc_tb_clock (
  output logic o_clk
);

  initial o_clk = 1'b0;
  always #2 o_clk = ~o_clk;  // 4 ns period

endmodule

// File: duc_checker.sv
`timescale 1ns/100ps

module duc_checker import duc_pkg::*; (
  input logic       clk,
  input logic       reset,
  input logic       i_clear,
  input logic       i_out_valid,
  input logic       i_out_ready,
  input iq_sample_t i_out_data,
  input logic       i_rate_load
);

  int unsigned fail_cnt = 0;  // Assertion failures so far

  // Stalled output word stays put until taken
  stall_hold: assert property (@(posedge clk) disable iff (reset || i_clear)
    i_out_valid && !i_out_ready |=> i_out_valid && $stable(i_out_data))
    else begin
      fail_cnt++;
      $error("Output word dropped or changed while stalled");
    end

  reset_quiet: assert property (@(posedge clk) reset |=> !i_out_valid)
    else begin
      fail_cnt++;
      $error("o_valid high during reset");
    end

  load_pulse: assert property (@(posedge clk) disable iff (reset)
    i_rate_load |=> !i_rate_load)
    else begin
      fail_cnt++;
      $error("CIC reload pulse longer than one cycle");
    end

endmodule

bind duc_top duc_checker u_checker (
  .clk(clk), .reset(reset), .i_clear(i_clear),
  .i_out_valid(o_valid), .i_out_ready(i_ready), .i_out_data(o_data),
  .i_rate_load(rate_load)
);

// File: duc_top.sv
`timescale 1ns/100ps

module duc_top import duc_pkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 i_clear,
  input  logic                 i_set_stb,
  input  logic [SR_ADDR_W-1:0] i_set_addr,
  input  set_word_u            i_set_data,
  input  iq_sample_t           i_data,
  input  logic                 i_valid,
  output logic                 o_ready,
  output iq_sample_t           o_data,
  output logic                 o_valid,
  input  logic                 i_ready
);

  logic [RATE_LOG_W-1:0] rate_log;
  logic                  rate_load;     // CIC restart on a new rate
  logic [PHASE_W-1:0]    phase_inc;
  logic [SCALE_W-1:0]    scale_factor;
  iq_sample_t            cic_data;
  logic                  cic_valid;
  logic                  rot_ready;
  iq_sample_t            rot_data;
  logic                  rot_valid;
  logic                  scl_ready;

  duc_settings u_settings (
    .clk(clk), .reset(reset), .i_clear(i_clear),
    .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .i_accept(i_valid & o_ready),  // Any input transfer marks the chain busy
    .o_rate_log(rate_log), .o_rate_load(rate_load),
    .o_phase_inc(phase_inc), .o_scale(scale_factor)
  );

  cic_interp u_cic (
    .clk(clk), .reset(reset), .i_clear(i_clear),
    .i_rate_log(rate_log), .i_rate_load(rate_load),
    .i_data(i_data), .i_valid(i_valid), .o_ready(o_ready),
    .o_data(cic_data), .o_valid(cic_valid), .i_ready(rot_ready)
  );

  phase_rotator u_rotator (
    .clk(clk), .reset(reset), .i_clear(i_clear), .i_phase_inc(phase_inc),
    .i_data(cic_data), .i_valid(cic_valid), .o_ready(rot_ready),
    .o_data(rot_data), .o_valid(rot_valid), .i_ready(scl_ready)
  );

  iq_scaler u_scaler (
    .clk(clk), .reset(reset), .i_clear(i_clear), .i_scale(scale_factor),
    .i_data(rot_data), .i_valid(rot_valid), .o_ready(scl_ready),
    .o_data(o_data), .o_valid(o_valid), .i_ready(i_ready)
  );

endmodule

// File: iq_scaler.sv
`timescale 1ns/100ps

module iq_scaler import duc_pkg::*; (
  input  logic               clk,
  input  logic               reset,
  input  logic               i_clear,
  input  logic [SCALE_W-1:0] i_scale,
  input  iq_sample_t         i_data,
  input  logic               i_valid,
  output logic               o_ready,
  output iq_sample_t         o_data,
  output logic               o_valid,
  input  logic               i_ready
);

  logic signed [SCALED_W-1:0] prod_i;
  logic signed [SCALED_W-1:0] prod_q;
  iq_sample_t                 res;        // Scaled, rounded, clipped
  iq_sample_t                 skid_data;
  logic                       skid_vld;   // Parked word from a stalled cycle

  assign o_ready = ~skid_vld;  // Straight from a flop

  // Unsigned scale, zero-extended into a signed multiply
  assign prod_i = i_data.i * $signed({1'b0, i_scale});
  assign prod_q = i_data.q * $signed({1'b0, i_scale});

  always_comb begin
    res.i = sat_sample((prod_i + SCALED_W'(SCALE_RND)) >>> SCALE_FRAC);  // Round half up
    res.q = sat_sample((prod_q + SCALED_W'(SCALE_RND)) >>> SCALE_FRAC);
  end

  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      o_valid  <= 1'b0;
      skid_vld <= 1'b0;
    end else if (o_valid && !i_ready) begin
      if (i_valid && !skid_vld) skid_vld <= 1'b1;  // Accepted with the output stuck
    end else if (skid_vld) begin
      o_valid  <= 1'b1;  // Skid word moves out
      skid_vld <= 1'b0;
    end else begin
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (o_valid && !i_ready) begin
      if (i_valid && !skid_vld) skid_data <= res;
    end else if (skid_vld) begin
      o_data <= skid_data;
    end else if (i_valid) begin
      o_data <= res;
    end
  end

endmodule

// File: phase_rotator.sv
`timescale 1ns/100ps

module phase_rotator import duc_pkg::*; (
  input  logic               clk,
  input  logic               reset,
  input  logic               i_clear,
  input  logic [PHASE_W-1:0] i_phase_inc,
  input  iq_sample_t         i_data,
  input  logic               i_valid,
  output logic               o_ready,
  output iq_sample_t         o_data,
  output logic               o_valid,
  input  logic               i_ready
);

  logic [PHASE_W-1:0]         phase;  // NCO accumulator
  logic                       pipe_en;
  logic                       in_acc;
  logic signed [CORDIC_W-1:0] x_in;
  logic signed [CORDIC_W-1:0] y_in;
  logic signed [CORDIC_W-1:0] x_pre;
  logic signed [CORDIC_W-1:0] y_pre;
  logic [PHASE_W-1:0]         z_pre;

  // Stage 0 is the quadrant step, stage k+1 follows iteration k
  logic signed [CORDIC_W-1:0] x_r  [0:CORDIC_ITER];
  logic signed [CORDIC_W-1:0] y_r  [0:CORDIC_ITER];
  logic [PHASE_W-1:0]         z_r  [0:CORDIC_ITER-1];  // Residual angle
  logic signed [CORDIC_W-1:0] x_nx [0:CORDIC_ITER-1];
  logic signed [CORDIC_W-1:0] y_nx [0:CORDIC_ITER-1];
  logic [PHASE_W-1:0]         z_nx [0:CORDIC_ITER-2];
  logic [CORDIC_ITER-1:0]     rot_pos;  // Rotate counter-clockwise
  logic [CORDIC_ITER:0]       vld;

  assign pipe_en = ~vld[CORDIC_ITER] | i_ready;  // Whole pipe moves or holds
  assign o_ready = pipe_en;
  assign in_acc  = i_valid & pipe_en;
  assign o_valid = vld[CORDIC_ITER];

  assign x_in = CORDIC_W'(i_data.i) <<< CORDIC_FRAC;
  assign y_in = CORDIC_W'(i_data.q) <<< CORDIC_FRAC;

  // Exact rotation by a multiple of 90 degrees, residual below 90
  always_comb begin
    unique case (phase[PHASE_W-1 -: 2])
      2'd0: begin
        x_pre = x_in;
        y_pre = y_in;
      end
      2'd1: begin
        x_pre = -y_in;
        y_pre = x_in;
      end
      2'd2: begin
        x_pre = -x_in;
        y_pre = -y_in;
      end
      default: begin
        x_pre = y_in;
        y_pre = -x_in;
      end
    endcase
    z_pre = {2'b00, phase[PHASE_W-3:0]};
  end

  always_comb begin
    for (int k = 0; k < CORDIC_ITER; k++) begin
      rot_pos[k] = ~z_r[k][PHASE_W-1];  // Sign of the residual
      if (rot_pos[k]) begin
        x_nx[k] = x_r[k] - (y_r[k] >>> k);
        y_nx[k] = y_r[k] + (x_r[k] >>> k);
      end else begin
        x_nx[k] = x_r[k] + (y_r[k] >>> k);
        y_nx[k] = y_r[k] - (x_r[k] >>> k);
      end
    end
    // Last stage needs no angle
    for (int k = 0; k < CORDIC_ITER - 1; k++) begin
      z_nx[k] = rot_pos[k] ? z_r[k] - CORDIC_ATAN[k] : z_r[k] + CORDIC_ATAN[k];
    end
  end

  always_ff @(posedge clk) begin
    if (reset || i_clear) phase <= '0;
    else if (in_acc) phase <= phase + i_phase_inc;  // Sample took the old phase
  end

  always_ff @(posedge clk) begin
    if (reset || i_clear) vld <= '0;  // Drops items in flight
    else if (pipe_en) vld <= {vld[CORDIC_ITER-1:0], i_valid};
  end

  always_ff @(posedge clk) begin
    if (pipe_en) begin
      x_r[0] <= x_pre;
      y_r[0] <= y_pre;
      z_r[0] <= z_pre;
      for (int k = 0; k < CORDIC_ITER; k++) begin
        x_r[k+1] <= x_nx[k];
        y_r[k+1] <= y_nx[k];
      end
      for (int k = 1; k < CORDIC_ITER; k++) begin
        z_r[k] <= z_nx[k-1];
      end
    end
  end

  // Drop fraction bits, gain of about 1.647 stays in
  always_comb begin
    o_data.i = sat_sample(SCALED_W'(x_r[CORDIC_ITER] >>> CORDIC_FRAC));
    o_data.q = sat_sample(SCALED_W'(y_r[CORDIC_ITER] >>> CORDIC_FRAC));
  end

endmodule

// File: cic_interp.sv
`timescale 1ns/100ps

module cic_interp import duc_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  i_clear,
  input  logic [RATE_LOG_W-1:0] i_rate_log,
  input  logic                  i_rate_load,
  input  iq_sample_t            i_data,
  input  logic                  i_valid,
  output logic                  o_ready,
  output iq_sample_t            o_data,
  output logic                  o_valid,
  input  logic                  i_ready
);

  // Index 0 is the I rail, 1 is Q
  logic signed [CIC_W-1:0] x_in    [2];  // Input widened to CIC width
  logic signed [CIC_W-1:0] x_dly   [2];  // Comb 1 delay
  logic signed [CIC_W-1:0] c1      [2];
  logic signed [CIC_W-1:0] c1_dly  [2];  // Comb 2 delay
  logic signed [CIC_W-1:0] c2      [2];
  logic signed [CIC_W-1:0] int1    [2];
  logic signed [CIC_W-1:0] int2    [2];
  logic signed [CIC_W-1:0] int1_nx [2];
  logic signed [CIC_W-1:0] int2_nx [2];
  logic signed [CIC_W-1:0] y_shift [2];  // Gain R removed

  logic [RATE_LOG_MAX-1:0] rep_cnt;  // Outputs owed after the one shown
  logic                    in_acc;
  logic                    out_acc;
  logic                    step;     // Integrators advance one output sample
  logic                    flush;

  assign flush   = i_clear | i_rate_load;
  assign out_acc = o_valid & i_ready;
  assign o_ready = (rep_cnt == '0) & (~o_valid | i_ready);  // Last owed output leaving
  assign in_acc  = i_valid & o_ready;
  assign step    = in_acc | (out_acc & (rep_cnt != '0));

  always_comb begin
    x_in[0] = CIC_W'(i_data.i);
    x_in[1] = CIC_W'(i_data.q);
    for (int r = 0; r < 2; r++) begin
      // Combs at the input rate
      c1[r] = x_in[r] - x_dly[r];
      c2[r] = c1[r] - c1_dly[r];
      // Zero stuffing: comb output only on the first output of each input
      int1_nx[r] = in_acc ? int1[r] + c2[r] : int1[r];
      int2_nx[r] = int2[r] + int1_nx[r];
      y_shift[r] = int2_nx[r] >>> i_rate_log;  // Two stages, gain is exactly R
    end
  end

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      for (int r = 0; r < 2; r++) begin
        x_dly[r]  <= '0;
        c1_dly[r] <= '0;
        int1[r]   <= '0;
        int2[r]   <= '0;
      end
      rep_cnt <= '0;
      o_valid <= 1'b0;
    end else begin
      if (in_acc) begin
        for (int r = 0; r < 2; r++) begin
          x_dly[r]  <= x_in[r];
          c1_dly[r] <= c1[r];
        end
        rep_cnt <= RATE_LOG_MAX'((1 << i_rate_log) - 1);
        o_valid <= 1'b1;
      end else if (out_acc) begin
        if (rep_cnt != '0) rep_cnt <= rep_cnt - 1'b1;
        else o_valid <= 1'b0;  // All R outputs delivered
      end
      if (step) begin
        for (int r = 0; r < 2; r++) begin
          int1[r] <= int1_nx[r];
          int2[r] <= int2_nx[r];
        end
      end
    end
  end

  // Output word, held under back-pressure
  always_ff @(posedge clk) begin
    if (step) begin
      o_data.i <= y_shift[0][SAMPLE_W-1:0];
      o_data.q <= y_shift[1][SAMPLE_W-1:0];
    end
  end

endmodule

// File: duc_settings.sv
`timescale 1ns/100ps

module duc_settings import duc_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  i_clear,
  input  logic                  i_set_stb,
  input  logic [SR_ADDR_W-1:0]  i_set_addr,
  input  set_word_u             i_set_data,
  input  logic                  i_accept,    // Input transfer at the chain head
  output logic [RATE_LOG_W-1:0] o_rate_log,
  output logic                  o_rate_load, // One cycle, with the new rate
  output logic [PHASE_W-1:0]    o_phase_inc,
  output logic [SCALE_W-1:0]    o_scale
);

  logic                  active;     // Samples went in since the last clear
  logic                  rate_hold;  // Rate written, not applied yet
  logic                  rate_wr;
  logic                  rate_go;
  logic [RATE_LOG_W-1:0] rate_req;   // Written rate, limited to R = 16
  logic [RATE_LOG_W-1:0] rate_new;

  assign rate_wr  = i_set_stb && (i_set_addr == SR_INTERP);
  assign rate_req = (i_set_data.interp.rate_log > RATE_LOG_W'(RATE_LOG_MAX)) ?
                    RATE_LOG_W'(RATE_LOG_MAX) : i_set_data.interp.rate_log;
  // Apply only when idle; never two load pulses back to back
  assign rate_go  = ~active & ~o_rate_load & (rate_wr | rate_hold);

  always_ff @(posedge clk) begin
    if (reset) begin
      o_phase_inc <= '0;
      o_scale     <= SCALE_W'(SCALE_UNITY);  // Unity gain
    end else if (i_set_stb) begin
      if (i_set_addr == SR_PHASE_INC) o_phase_inc <= i_set_data.phase.inc;
      if (i_set_addr == SR_SCALE)     o_scale     <= i_set_data.scale.factor;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      active      <= 1'b0;
      rate_hold   <= 1'b0;
      o_rate_log  <= '0;  // R = 1
      o_rate_load <= 1'b0;
    end else begin
      if (i_clear) active <= 1'b0;
      else if (i_accept) active <= 1'b1;

      if (rate_go) begin
        rate_hold   <= 1'b0;
        o_rate_log  <= rate_wr ? rate_req : rate_new;  // Fresh write wins
        o_rate_load <= 1'b1;
      end else begin
        if (rate_wr) rate_hold <= 1'b1;  // Busy, park it
        o_rate_load <= 1'b0;
      end
    end
  end

  // Last written rate
  always_ff @(posedge clk) begin
    if (rate_wr) rate_new <= rate_req;
  end

endmodule

// File: duc_pkg.sv
package duc_pkg;

  localparam int SAMPLE_W     = 16;                         // One I or Q rail
  localparam int SCALE_W      = 18;                         // Unsigned scale factor
  localparam int SCALE_FRAC   = 14;                         // Scale binary point
  localparam int SCALE_UNITY  = 1 << SCALE_FRAC;            // Gain of 1.0
  localparam int SCALE_RND    = 1 << (SCALE_FRAC - 1);      // Half an LSB after the shift
  localparam int SCALED_W     = SAMPLE_W + SCALE_W + 1;     // Signed product width
  localparam int PHASE_W      = 16;                         // Full turn is 2^PHASE_W
  localparam int CIC_EXTRA_W  = 4;                          // Growth for R up to 16
  localparam int CIC_W        = SAMPLE_W + CIC_EXTRA_W;
  localparam int RATE_LOG_W   = 3;
  localparam int RATE_LOG_MAX = 4;                          // R = 16 at most
  localparam int CORDIC_ITER  = 14;                         // Also the rotator stage count
  localparam int CORDIC_W     = 20;
  localparam int CORDIC_FRAC  = 2;                          // Fraction bits under the sample
  localparam int SR_ADDR_W    = 8;
  localparam int SET_W        = 32;

  localparam logic signed [SAMPLE_W-1:0] SAMPLE_MAX = 16'sh7fff;
  localparam logic signed [SAMPLE_W-1:0] SAMPLE_MIN = -SAMPLE_MAX;  // Symmetric clip

  // Settings bus addresses
  localparam logic [SR_ADDR_W-1:0] SR_PHASE_INC = 8'd0;
  localparam logic [SR_ADDR_W-1:0] SR_SCALE     = 8'd1;
  localparam logic [SR_ADDR_W-1:0] SR_INTERP    = 8'd2;

  // atan(2^-k) scaled so that 2^PHASE_W is one turn
  localparam logic [PHASE_W-1:0] CORDIC_ATAN [0:CORDIC_ITER-1] = '{
    16'd8192, 16'd4836, 16'd2555, 16'd1297, 16'd651, 16'd326, 16'd163,
    16'd81,   16'd41,   16'd20,   16'd10,   16'd5,   16'd3,   16'd1
  };

  typedef struct packed {
    logic signed [SAMPLE_W-1:0] i;  // Upper half of the word
    logic signed [SAMPLE_W-1:0] q;
  } iq_sample_t;

  typedef struct packed {
    logic [SET_W-PHASE_W-1:0] rsvd;
    logic [PHASE_W-1:0]       inc;
  } set_phase_t;

  typedef struct packed {
    logic [SET_W-SCALE_W-1:0] rsvd;
    logic [SCALE_W-1:0]       factor;
  } set_scale_t;

  typedef struct packed {
    logic [SET_W-RATE_LOG_W-1:0] rsvd;
    logic [RATE_LOG_W-1:0]       rate_log;  // log2 of the CIC rate
  } set_interp_t;

  // Settings data word, view picked by address
  typedef union packed {
    set_phase_t  phase;
    set_scale_t  scale;
    set_interp_t interp;
  } set_word_u;

  // Clip a wide signed value to one rail
  function automatic logic signed [SAMPLE_W-1:0] sat_sample(
    input logic signed [SCALED_W-1:0] v
  );
    if (v > SAMPLE_MAX) return SAMPLE_MAX;
    if (v < SAMPLE_MIN) return SAMPLE_MIN;
    return v[SAMPLE_W-1:0];
  endfunction

endpackage
